// ==== common/cam_bist_pkg.sv ====
`default_nettype none

package cam_bist_pkg;

  // ==================================================
  // Array geometry
  // ==================================================
  localparam int CAM_ENTRIES = 16;
  localparam int CAM_DWIDTH  = 8;
  localparam int CAM_AWIDTH  = 4;
  // Compare bits folded onto each read bit
  localparam int CAM_FOLD    = CAM_ENTRIES / CAM_DWIDTH;
  // Issue to result, reads and searches alike
  localparam int CAM_LAT     = 2;

  // ==================================================
  // Expected match-line select codes
  // ==================================================
  localparam logic [1:0] SEL_ALL_MATCH       = 2'b00;
  localparam logic [1:0] SEL_SINGLE_MATCH    = 2'b01;
  localparam logic [1:0] SEL_SINGLE_MISMATCH = 2'b10;
  localparam logic [1:0] SEL_ALL_MISMATCH    = 2'b11;

  // ==================================================
  // Sequencer phases, in run order
  // ==================================================
  localparam logic [2:0] PH_IDLE        = 3'd0;
  localparam logic [2:0] PH_WR_UNIQUE   = 3'd1;
  localparam logic [2:0] PH_RD_UNIQUE   = 3'd2;
  localparam logic [2:0] PH_SRCH_SINGLE = 3'd3;
  localparam logic [2:0] PH_SRCH_NONE   = 3'd4;
  localparam logic [2:0] PH_WR_BG       = 3'd5;
  localparam logic [2:0] PH_SRCH_ALL    = 3'd6;
  localparam logic [2:0] PH_SINGLE_MISS = 3'd7;

  // Six phases of 16 ops plus the 3-op disturb walk
  localparam int BIST_OPS = 144;

  // Background and disturb patterns
  localparam logic [CAM_DWIDTH-1:0] BG_DATA   = 8'h00;
  localparam logic [CAM_DWIDTH-1:0] MISS_DATA = 8'hFF;

  // Unique word of an entry: inverted index above, index below
  function automatic logic [CAM_DWIDTH-1:0] uniq_data(input logic [CAM_AWIDTH-1:0] a);
    return {~a, a};
  endfunction

  // Same index in both nibbles, never equal to any unique word
  function automatic logic [CAM_DWIDTH-1:0] none_key(input logic [CAM_AWIDTH-1:0] a);
    return {a, a};
  endfunction

endpackage

`default_nettype wire

// ==== hw/cam/cam_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_array (
  input  wire logic                                bist_clk,
  input  wire logic                                arst_n,
  input  wire logic                                wr_en,
  input  wire logic                                rd_en,
  input  wire logic                                srch_en,
  input  wire logic [cam_bist_pkg::CAM_AWIDTH-1:0]  addr,
  input  wire logic [cam_bist_pkg::CAM_DWIDTH-1:0]  wdata,
  input  wire logic [cam_bist_pkg::CAM_DWIDTH-1:0]  key,
  input  wire logic                                stuck_en,
  input  wire logic                                flip_en,
  input  wire logic [cam_bist_pkg::CAM_AWIDTH-1:0]  fault_entry,
  output logic      [cam_bist_pkg::CAM_DWIDTH-1:0]  rd_data,
  output logic      [cam_bist_pkg::CAM_ENTRIES-1:0] match_lines
);

  // Storage
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  mem [cam_bist_pkg::CAM_ENTRIES];

  // Request stage
  logic                                 rd_q;
  logic                                 srch_q;
  logic [cam_bist_pkg::CAM_AWIDTH-1:0]  addr_q;
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  key_q;

  // Result stage inputs
  logic [cam_bist_pkg::CAM_ENTRIES-1:0] hit;
  logic [cam_bist_pkg::CAM_ENTRIES-1:0] stuck_mask;
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  flip_mask;

  // ==================================================
  // Write port
  // ==================================================
  // Write lands at the edge, visible to the next compare
  always_ff @(posedge bist_clk) begin
    if (wr_en) begin
      mem[addr] <= wdata;
    end
  end

  // ==================================================
  // Request stage
  // ==================================================
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_q   <= 1'b0;
      srch_q <= 1'b0;
    end else begin
      rd_q   <= rd_en;
      srch_q <= srch_en;
    end
  end

  always_ff @(posedge bist_clk) begin
    addr_q <= addr;
    key_q  <= key;
  end

  // ==================================================
  // Compare and defect injection
  // ==================================================
  // One comparator per entry against the registered key
  always_comb begin
    for (int e = 0; e < cam_bist_pkg::CAM_ENTRIES; e++) begin
      hit[e] = (mem[e] == key_q);
    end
  end

  // Stuck-low match line at the faulty entry
  assign stuck_mask = stuck_en ? ({{(cam_bist_pkg::CAM_ENTRIES-1){1'b0}}, 1'b1} << fault_entry)
                               : '0;

  // Bit 0 flips only on reads of the faulty entry
  assign flip_mask = {{(cam_bist_pkg::CAM_DWIDTH-1){1'b0}}, flip_en && (addr_q == fault_entry)};

  // ==================================================
  // Result stage
  // ==================================================
  // Results hold between operations
  always_ff @(posedge bist_clk) begin
    if (rd_q) begin
      rd_data <= mem[addr_q] ^ flip_mask;
    end
    if (srch_q) begin
      match_lines <= hit & ~stuck_mask;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mbist/mbist_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module mbist_seq (
  input  wire logic                               bist_clk,
  input  wire logic                               arst_n,
  input  wire logic                               start,
  output logic                                    busy,
  output logic                                    done,
  output logic                                    wr_en,
  output logic                                    rd_en,
  output logic                                    srch_en,
  output logic     [cam_bist_pkg::CAM_AWIDTH-1:0] addr,
  output logic     [cam_bist_pkg::CAM_DWIDTH-1:0] wdata,
  output logic     [cam_bist_pkg::CAM_DWIDTH-1:0] key,
  output logic                                    cm_mode,
  output logic     [1:0]                          match_sel,
  output logic                                    chk_en,
  output logic     [cam_bist_pkg::CAM_DWIDTH-1:0] exp_data
);

  logic [2:0]                          phase;
  logic [cam_bist_pkg::CAM_AWIDTH-1:0] idx;
  // Sub-step of the disturb walk: write, search, restore
  logic [1:0]                          step;
  logic [7:0]                          op_cnt;
  // Wide enough for CAM_LAT
  logic [1:0]                          drain_cnt;
  logic                                issuing;
  logic                                last_op;
  logic                                phase_end;

  assign issuing   = (phase != cam_bist_pkg::PH_IDLE);
  assign last_op   = (int'(op_cnt) == cam_bist_pkg::BIST_OPS - 1);
  assign phase_end = (int'(idx) == cam_bist_pkg::CAM_ENTRIES - 1) &&
                     (phase != cam_bist_pkg::PH_SINGLE_MISS || step == 2'd2);

  // ==================================================
  // Phase walk and run control
  // ==================================================
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase     <= cam_bist_pkg::PH_IDLE;
      idx       <= '0;
      step      <= '0;
      op_cnt    <= '0;
      drain_cnt <= '0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else if (start && !busy) begin
      phase  <= cam_bist_pkg::PH_WR_UNIQUE;
      idx    <= '0;
      step   <= '0;
      op_cnt <= '0;
      busy   <= 1'b1;
      done   <= 1'b0;
    end else if (issuing) begin
      op_cnt <= op_cnt + 8'd1;
      if (last_op) begin
        // Let the in-flight checks retire before done
        phase     <= cam_bist_pkg::PH_IDLE;
        drain_cnt <= 2'(cam_bist_pkg::CAM_LAT);
      end else if (phase_end) begin
        phase <= phase + 3'd1;
        idx   <= '0;
        step  <= '0;
      end else if (phase == cam_bist_pkg::PH_SINGLE_MISS && step != 2'd2) begin
        step <= step + 2'd1;
      end else begin
        idx  <= idx + 1'b1;
        step <= '0;
      end
    end else if (drain_cnt != '0) begin
      drain_cnt <= drain_cnt - 2'd1;
      if (drain_cnt == 2'd1) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Every op addresses the current index
  assign addr = idx;

  // ==================================================
  // Operation decode
  // ==================================================
  always_comb begin
    wr_en     = 1'b0;
    rd_en     = 1'b0;
    srch_en   = 1'b0;
    wdata     = cam_bist_pkg::BG_DATA;
    key       = cam_bist_pkg::BG_DATA;
    cm_mode   = 1'b0;
    match_sel = cam_bist_pkg::SEL_ALL_MATCH;
    chk_en    = 1'b0;
    exp_data  = '0;
    case (phase)
      cam_bist_pkg::PH_WR_UNIQUE: begin
        wr_en = 1'b1;
        wdata = cam_bist_pkg::uniq_data(idx);
      end
      cam_bist_pkg::PH_RD_UNIQUE: begin
        rd_en    = 1'b1;
        chk_en   = 1'b1;
        exp_data = cam_bist_pkg::uniq_data(idx);
      end
      cam_bist_pkg::PH_SRCH_SINGLE: begin
        // Own word hits only this entry
        srch_en   = 1'b1;
        key       = cam_bist_pkg::uniq_data(idx);
        cm_mode   = 1'b1;
        match_sel = cam_bist_pkg::SEL_SINGLE_MATCH;
        chk_en    = 1'b1;
      end
      cam_bist_pkg::PH_SRCH_NONE: begin
        srch_en   = 1'b1;
        key       = cam_bist_pkg::none_key(idx);
        cm_mode   = 1'b1;
        match_sel = cam_bist_pkg::SEL_ALL_MISMATCH;
        chk_en    = 1'b1;
      end
      cam_bist_pkg::PH_WR_BG: begin
        wr_en = 1'b1;
      end
      cam_bist_pkg::PH_SRCH_ALL: begin
        srch_en = 1'b1;
        cm_mode = 1'b1;
        chk_en  = 1'b1;
      end
      cam_bist_pkg::PH_SINGLE_MISS: begin
        if (step == 2'd1) begin
          // Background search misses only the disturbed entry
          srch_en   = 1'b1;
          cm_mode   = 1'b1;
          match_sel = cam_bist_pkg::SEL_SINGLE_MISMATCH;
          chk_en    = 1'b1;
        end else begin
          // Step 0 disturbs, step 2 restores
          wr_en = 1'b1;
          wdata = (step == 2'd0) ? cam_bist_pkg::MISS_DATA : cam_bist_pkg::BG_DATA;
        end
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/mbist/cam_mbist_outhandler.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_mbist_outhandler (
  input  wire logic                                bist_clk,
  input  wire logic                                arst_n,
  input  wire logic [cam_bist_pkg::CAM_AWIDTH-1:0]  addr,
  input  wire logic [1:0]                          match_sel,
  input  wire logic                                cm_mode,
  input  wire logic [cam_bist_pkg::CAM_ENTRIES-1:0] match_lines,
  input  wire logic [cam_bist_pkg::CAM_DWIDTH-1:0]  rd_data,
  output logic      [cam_bist_pkg::CAM_DWIDTH-1:0]  rd_word,
  output logic      [cam_bist_pkg::CAM_ENTRIES-1:0] match_ref
);

  // Operation info delayed to meet the array results
  logic [cam_bist_pkg::CAM_AWIDTH-1:0]  addr_pipe [cam_bist_pkg::CAM_LAT];
  logic [1:0]                           sel_pipe  [cam_bist_pkg::CAM_LAT];
  logic [cam_bist_pkg::CAM_LAT-1:0]     mode_pipe;

  logic [cam_bist_pkg::CAM_ENTRIES-1:0] one_hot;
  logic [cam_bist_pkg::CAM_ENTRIES-1:0] match_cmp;
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  fold_word;

  // ==================================================
  // Alignment to the array latency
  // ==================================================
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      sel_pipe  <= '{default: cam_bist_pkg::SEL_ALL_MATCH};
      mode_pipe <= '0;
    end else begin
      sel_pipe[0] <= match_sel;
      for (int s = 1; s < cam_bist_pkg::CAM_LAT; s++) begin
        sel_pipe[s] <= sel_pipe[s-1];
      end
      mode_pipe <= {mode_pipe[cam_bist_pkg::CAM_LAT-2:0], cm_mode};
    end
  end

  always_ff @(posedge bist_clk) begin
    addr_pipe[0] <= addr;
    for (int s = 1; s < cam_bist_pkg::CAM_LAT; s++) begin
      addr_pipe[s] <= addr_pipe[s-1];
    end
  end

  // ==================================================
  // Expected match lines
  // ==================================================
  assign one_hot = {{(cam_bist_pkg::CAM_ENTRIES-1){1'b0}}, 1'b1}
                   << addr_pipe[cam_bist_pkg::CAM_LAT-1];

  always_comb begin
    case (sel_pipe[cam_bist_pkg::CAM_LAT-1])
      cam_bist_pkg::SEL_ALL_MATCH:       match_ref = '1;
      cam_bist_pkg::SEL_SINGLE_MATCH:    match_ref = one_hot;
      cam_bist_pkg::SEL_SINGLE_MISMATCH: match_ref = ~one_hot;
      default:                           match_ref = '0;
    endcase
  end

  // ==================================================
  // Compare and compaction
  // ==================================================
  // Any set bit is a disagreeing match line
  assign match_cmp = match_ref ^ match_lines;

  // Bit k collects bits k, k+8, ... of the compare vector
  always_comb begin
    for (int k = 0; k < cam_bist_pkg::CAM_DWIDTH; k++) begin
      fold_word[k] = 1'b0;
      for (int f = 0; f < cam_bist_pkg::CAM_FOLD; f++) begin
        fold_word[k] = fold_word[k] | match_cmp[k + f*cam_bist_pkg::CAM_DWIDTH];
      end
    end
  end

  // Searches share the read-data path
  assign rd_word = mode_pipe[cam_bist_pkg::CAM_LAT-1] ? fold_word : rd_data;

endmodule

`default_nettype wire

// ==== hw/mbist/mbist_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module mbist_checker (
  input  wire logic                               bist_clk,
  input  wire logic                               arst_n,
  input  wire logic                               start,
  input  wire logic                               chk_en,
  input  wire logic [cam_bist_pkg::CAM_DWIDTH-1:0] exp_data,
  input  wire logic [cam_bist_pkg::CAM_AWIDTH-1:0] addr,
  input  wire logic [cam_bist_pkg::CAM_DWIDTH-1:0] rd_word,
  output logic                                    fail,
  output logic     [7:0]                          fail_count,
  output logic     [cam_bist_pkg::CAM_AWIDTH-1:0] first_fail_addr
);

  // Check pipeline, retires CAM_LAT cycles after issue
  logic [cam_bist_pkg::CAM_LAT-1:0]    chk_pipe;
  logic [cam_bist_pkg::CAM_DWIDTH-1:0] exp_pipe  [cam_bist_pkg::CAM_LAT];
  logic [cam_bist_pkg::CAM_AWIDTH-1:0] addr_pipe [cam_bist_pkg::CAM_LAT];
  logic                                mismatch;

  // ==================================================
  // Expectation delay
  // ==================================================
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      chk_pipe <= '0;
    end else begin
      chk_pipe <= {chk_pipe[cam_bist_pkg::CAM_LAT-2:0], chk_en};
    end
  end

  always_ff @(posedge bist_clk) begin
    exp_pipe[0]  <= exp_data;
    addr_pipe[0] <= addr;
    for (int s = 1; s < cam_bist_pkg::CAM_LAT; s++) begin
      exp_pipe[s]  <= exp_pipe[s-1];
      addr_pipe[s] <= addr_pipe[s-1];
    end
  end

  // Searches expect an all-zero folded word
  assign mismatch = chk_pipe[cam_bist_pkg::CAM_LAT-1] &&
                    (rd_word != exp_pipe[cam_bist_pkg::CAM_LAT-1]);

  // ==================================================
  // Sticky result
  // ==================================================
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      fail            <= 1'b0;
      fail_count      <= '0;
      first_fail_addr <= '0;
    end else if (start) begin
      fail            <= 1'b0;
      fail_count      <= '0;
      first_fail_addr <= '0;
    end else if (mismatch) begin
      fail <= 1'b1;
      // Count saturates at all ones
      if (fail_count != 8'hFF) begin
        fail_count <= fail_count + 8'd1;
      end
      // Only the first failure of a run is kept
      if (!fail) begin
        first_fail_addr <= addr_pipe[cam_bist_pkg::CAM_LAT-1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/cam_bist_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_bist_top (
  input  wire logic                                bist_clk,
  input  wire logic                                arst_n,
  input  wire logic                                start,
  input  wire logic                                stuck_en,
  input  wire logic                                flip_en,
  input  wire logic [cam_bist_pkg::CAM_AWIDTH-1:0]  fault_entry,
  output logic                                     busy,
  output logic                                     done,
  output logic                                     fail,
  output logic      [7:0]                          fail_count,
  output logic      [cam_bist_pkg::CAM_AWIDTH-1:0]  first_fail_addr,
  output logic      [cam_bist_pkg::CAM_ENTRIES-1:0] match_ref
);

  // Sequencer outputs
  logic                                 wr_en;
  logic                                 rd_en;
  logic                                 srch_en;
  logic [cam_bist_pkg::CAM_AWIDTH-1:0]  addr;
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  wdata;
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  key;
  logic                                 cm_mode;
  logic [1:0]                           match_sel;
  logic                                 chk_en;
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  exp_data;

  // Array results and the folded read path
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  rd_data;
  logic [cam_bist_pkg::CAM_ENTRIES-1:0] match_lines;
  logic [cam_bist_pkg::CAM_DWIDTH-1:0]  rd_word;

  // ==================================================
  // Input side
  // ==================================================
  mbist_seq seq_i (
    .bist_clk, .arst_n, .start, .busy, .done,
    .wr_en, .rd_en, .srch_en, .addr, .wdata, .key,
    .cm_mode, .match_sel, .chk_en, .exp_data
  );

  // Array under test
  cam_array array_i (
    .bist_clk, .arst_n, .wr_en, .rd_en, .srch_en, .addr, .wdata, .key,
    .stuck_en, .flip_en, .fault_entry, .rd_data, .match_lines
  );

  // ==================================================
  // Output side
  // ==================================================
  cam_mbist_outhandler outhandler_i (
    .bist_clk, .arst_n, .addr, .match_sel, .cm_mode,
    .match_lines, .rd_data, .rd_word, .match_ref
  );

  mbist_checker checker_i (
    .bist_clk, .arst_n, .start, .chk_en, .exp_data, .addr, .rd_word,
    .fail, .fail_count, .first_fail_addr
  );

endmodule

`default_nettype wire

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic bist_clk,
  output logic arst_n
);

  // 20 ns period
  initial begin
    bist_clk = 1'b0;
    forever #10 bist_clk = ~bist_clk;
  end

  // Reset held for 4 cycles, released just after an edge
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge bist_clk);
    #2 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/cam_bist_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_bist_assert (
  input wire logic       bist_clk,
  input wire logic       arst_n,
  input wire logic       start,
  input wire logic       busy,
  input wire logic       done,
  input wire logic       fail,
  input wire logic [7:0] fail_count,
  input wire logic       wr_en,
  input wire logic       rd_en,
  input wire logic       srch_en
);

  // ==================================================
  // Run status
  // ==================================================
  busy_done_excl: assert property (@(posedge bist_clk) disable iff (!arst_n)
    !(busy && done))
    else $error("busy and done are high in the same cycle");

  // Sticky flag only clears on a new run
  fail_sticky: assert property (@(posedge bist_clk) disable iff (!arst_n)
    $fell(fail) |-> $past(start))
    else $error("fail dropped with no start");

  // Count only moves up within a run
  count_monotonic: assert property (@(posedge bist_clk) disable iff (!arst_n)
    (fail_count < $past(fail_count)) |-> $past(start))
    else $error("fail_count went down with no start");

  // ==================================================
  // Array strobes
  // ==================================================
  one_op_per_cycle: assert property (@(posedge bist_clk) disable iff (!arst_n)
    $onehot0({wr_en, rd_en, srch_en}))
    else $error("more than one array strobe in a cycle");

endmodule

// Hooked onto the top level, ports matched by name
bind cam_bist_top cam_bist_assert assert_i (.*);

`default_nettype wire

// ==== sim/cam_bist_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_bist_tb;

  localparam int RESET_CYCLES    = 4;
  localparam int RUN_CYCLES      = cam_bist_pkg::BIST_OPS + 10;
  // Six runs plus reset
  localparam int WATCHDOG_CYCLES = 6 * RUN_CYCLES + RESET_CYCLES;

  logic                                 bist_clk;
  logic                                 arst_n;
  logic                                 start;
  logic                                 stuck_en;
  logic                                 flip_en;
  logic [cam_bist_pkg::CAM_AWIDTH-1:0]  fault_entry;
  logic                                 busy;
  logic                                 done;
  logic                                 fail;
  logic [7:0]                           fail_count;
  logic [cam_bist_pkg::CAM_AWIDTH-1:0]  first_fail_addr;
  logic [cam_bist_pkg::CAM_ENTRIES-1:0] match_ref;

  int   error_count  = 0;
  int   test_count   = 0;
  int   failed_tests = 0;
  // match_ref monitor state
  logic watch_ref    = 1'b0;
  logic seen_ones;
  logic seen_zeros;
  logic seen_onehot;
  logic seen_invhot;

  tb_clkgen clkgen_i (.bist_clk, .arst_n);

  cam_bist_top dut_i (
    .bist_clk, .arst_n, .start, .stuck_en, .flip_en, .fault_entry,
    .busy, .done, .fail, .fail_count, .first_fail_addr, .match_ref
  );

  // ==================================================
  // Reporting and expected values
  // ==================================================
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    error_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s at %0t", msg, $time);
    error_count++;
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    test_count++;
    if (error_count == errs_at_start) begin
      $display("PASS  %s", name);
    end else begin
      failed_tests++;
      $display("FAIL  %s with %0d errors", name, error_count - errs_at_start);
    end
  endtask

  // Failing checks per run, walked phase by phase
  function automatic int expected_fails(input logic stuck, input logic flip,
                                        input logic [3:0] e);
    int n;
    n = 0;
    for (int a = 0; a < cam_bist_pkg::CAM_ENTRIES; a++) begin
      // Read phase, bit 0 of entry e flips
      if (flip && a == e) n++;
      // Single-match search at e loses its own line
      if (stuck && a == e) n++;
      // All-match search misses line e every time
      if (stuck) n++;
      // Single-mismatch at a expects line e high unless a is e
      if (stuck && a != e) n++;
    end
    return n;
  endfunction

  // ==================================================
  // Run control
  // ==================================================
  // Fault setup and a one-cycle start, both 2 ns after the edge
  task automatic start_run(input logic stuck, input logic flip, input logic [3:0] e);
    @(posedge bist_clk);
    #2;
    stuck_en    = stuck;
    flip_en     = flip;
    fault_entry = e;
    start       = 1'b1;
    @(posedge bist_clk);
    #2 start = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (done !== 1'b1 && cycles < RUN_CYCLES) begin
      @(negedge bist_clk);
      cycles++;
    end
    if (done !== 1'b1) report_failure("BIST run never raised done");
  endtask

  task automatic check_result(input int exp_count, input logic [3:0] exp_addr);
    if (done !== 1'b1) report_mismatch("done", 32'(done), 32'h1);
    if (busy !== 1'b0) report_mismatch("busy", 32'(busy), 32'h0);
    if (fail !== (exp_count != 0)) report_mismatch("fail", 32'(fail), 32'(exp_count != 0));
    if (fail_count !== 8'(exp_count)) begin
      report_mismatch("fail_count", 32'(fail_count), 32'(exp_count));
    end
    if (first_fail_addr !== exp_addr) begin
      report_mismatch("first_fail_addr", 32'(first_fail_addr), 32'(exp_addr));
    end
  endtask

  // ==================================================
  // Tests
  // ==================================================
  task automatic test_clean_run();
    int errs_at_start;
    errs_at_start = error_count;
    // Idle straight out of reset
    if (busy !== 1'b0) report_mismatch("busy", 32'(busy), 32'h0);
    if (done !== 1'b0) report_mismatch("done", 32'(done), 32'h0);
    if (fail !== 1'b0) report_mismatch("fail", 32'(fail), 32'h0);
    start_run(1'b0, 1'b0, 4'h0);
    wait_done();
    check_result(0, 4'h0);
    finish_test("clean run after reset", errs_at_start);
  endtask

  task automatic test_fault_run(input string name, input logic stuck, input logic flip,
                                input logic [3:0] e);
    int errs_at_start;
    errs_at_start = error_count;
    start_run(stuck, flip, e);
    wait_done();
    // Every fault sits at e, so e is the first failure
    check_result(expected_fails(stuck, flip, e), e);
    finish_test(name, errs_at_start);
  endtask

  task automatic test_rerun_clears();
    int errs_at_start;
    errs_at_start = error_count;
    if (fail !== 1'b1) report_mismatch("fail", 32'(fail), 32'h1);
    start_run(1'b0, 1'b0, 4'h0);
    // Start has wiped the old result
    @(negedge bist_clk);
    if (busy !== 1'b1) report_mismatch("busy", 32'(busy), 32'h1);
    if (fail !== 1'b0) report_mismatch("fail", 32'(fail), 32'h0);
    if (fail_count !== 8'h00) report_mismatch("fail_count", 32'(fail_count), 32'h0);
    wait_done();
    check_result(0, 4'h0);
    finish_test("clean rerun after failing run", errs_at_start);
  endtask

  task automatic test_match_ref_forms();
    int errs_at_start;
    errs_at_start = error_count;
    seen_ones   = 1'b0;
    seen_zeros  = 1'b0;
    seen_onehot = 1'b0;
    seen_invhot = 1'b0;
    start_run(1'b0, 1'b0, 4'h0);
    watch_ref = 1'b1;
    wait_done();
    watch_ref = 1'b0;
    if (!seen_ones) report_failure("match_ref was never all ones");
    if (!seen_zeros) report_failure("match_ref was never all zeros");
    if (!seen_onehot) report_failure("match_ref was never one-hot");
    if (!seen_invhot) report_failure("match_ref was never inverted one-hot");
    finish_test("match_ref forms", errs_at_start);
  endtask

  // Legal forms of match_ref, checked mid-cycle
  always @(negedge bist_clk) begin
    if (watch_ref) begin
      if ($isunknown(match_ref)) begin
        report_failure("match_ref holds unknown bits");
      end else if (match_ref == '1) begin
        seen_ones = 1'b1;
      end else if (match_ref == '0) begin
        seen_zeros = 1'b1;
      end else if ($countones(match_ref) == 1) begin
        seen_onehot = 1'b1;
      end else if ($countones(~match_ref) == 1) begin
        seen_invhot = 1'b1;
      end else begin
        report_mismatch("match_ref", 32'(match_ref), 32'h0000ffff);
      end
    end
  end

  // ==================================================
  // Main sequence and watchdog
  // ==================================================
  initial begin
    int         seed_ret;
    logic [3:0] e;
    start       = 1'b0;
    stuck_en    = 1'b0;
    flip_en     = 1'b0;
    fault_entry = '0;
    seed_ret    = $urandom(32'h83c34cdc);
    wait (arst_n === 1'b1);
    @(negedge bist_clk);
    test_clean_run();
    e = 4'($urandom_range(15, 0));
    test_fault_run("stuck match line", 1'b1, 1'b0, e);
    e = 4'($urandom_range(15, 0));
    test_fault_run("flipped read bit", 1'b0, 1'b1, e);
    e = 4'($urandom_range(15, 0));
    test_fault_run("stuck line and flipped bit", 1'b1, 1'b1, e);
    test_rerun_clears();
    test_match_ref_forms();
    $display("Tests run %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge bist_clk);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/cam_bist_pkg.sv
hw/cam/cam_array.sv
hw/mbist/mbist_seq.sv
hw/mbist/cam_mbist_outhandler.sv
hw/mbist/mbist_checker.sv
hw/cam_bist_top.sv
sim/tb_clkgen.sv
sim/cam_bist_assert.sv
sim/cam_bist_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CAM BIST simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module cam_bist_tb -o cam_bist_sim \
  && ./obj_dir/cam_bist_sim | tee /dev/stderr | grep -q "Done: no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
